//--- design/rv_core_cfg.svh
/* Core configuration switches for exception catching */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Flag unsupported or malformed encodings as illegal
`define RV_CATCH_ILLEGAL 1

// Flag taken jumps and branches to a target with bit 1 set
`define RV_CATCH_MISALIGNED_JMP 1

`endif

//--- design/rv_core_top.sv
/* RV32I three-stage core, decode, execute and writeback around the register file */
`default_nettype none

module rv_core_top (
  input  logic        clk,
  input  logic        rstz,
  // Instruction stream
  input  logic        instr_vld,
  output logic        instr_rdy,
  input  logic [31:0] instr_pc,
  input  logic [31:0] instr_word,
  // Retired results
  output logic        result_vld,
  input  logic        result_rdy,
  output logic [31:0] result_pc,
  output logic [4:0]  result_rd,
  output logic [31:0] result_data,
  output logic        result_wr,
  output logic        result_jump,
  output logic [31:0] result_target,
  output logic        result_illegal,
  output logic        result_misaligned
);

  stage_if #(.payload_t(rv_pipe_pkg::decode_t)) dec_if ();
  stage_if #(.payload_t(rv_pipe_pkg::exec_t))   exe_if ();
  regfile_if rf_if ();

  rv_decode u_rv_decode (
    .clk        (clk),
    .rstz       (rstz),
    .instr_vld  (instr_vld),
    .instr_rdy  (instr_rdy),
    .instr_pc   (instr_pc),
    .instr_word (instr_word),
    .rf         (rf_if.read),
    .out        (dec_if.source)
  );

  rv_execute u_rv_execute (
    .clk  (clk),
    .rstz (rstz),
    .in   (dec_if.sink),
    .out  (exe_if.source)
  );

  rv_writeback u_rv_writeback (
    .clk               (clk),
    .rstz              (rstz),
    .in                (exe_if.sink),
    .rf                (rf_if.write),
    .result_vld        (result_vld),
    .result_rdy        (result_rdy),
    .result_pc         (result_pc),
    .result_rd         (result_rd),
    .result_data       (result_data),
    .result_wr         (result_wr),
    .result_jump       (result_jump),
    .result_target     (result_target),
    .result_illegal    (result_illegal),
    .result_misaligned (result_misaligned)
  );

  rv_regfile u_rv_regfile (
    .clk  (clk),
    .rstz (rstz),
    .rf   (rf_if.storage)
  );

endmodule

`default_nettype wire

//--- design/rv_decode.sv
/* RV32I decode stage with operand fetch and forwarding, branch evaluation,
   target generation, exception flags and hazard scoreboard */
`default_nettype none
`include "rv_core_cfg.svh"

module rv_decode (
  input  logic        clk,
  input  logic        rstz,
  input  logic        instr_vld,
  output logic        instr_rdy,
  input  logic [31:0] instr_pc,
  input  logic [31:0] instr_word,
  regfile_if.read     rf,
  stage_if.source     out
);

  rv_isa_pkg::opcode_e  op;
  rv_isa_pkg::aluop_e   aluop;
  rv_pipe_pkg::decode_t dec;

  logic [4:0]  rs1, rs2, rd;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i, imm_u, imm_j, imm_b;
  logic [31:0] rs1_data, rs2_data;
  logic [31:0] op1, op2, base, offset, target_sum, target;
  logic        instr_valid, writer, rs1_en, rs2_en;
  logic        taken, jump, illegal, misaligned, regwr;
  logic [31:1] pending;
  logic [31:0] pend_map, clr_mask, set_mask;
  logic        rs1_hz, rs2_hz, rd_hz, stall, issue;

  // Instruction fields
  assign op     = rv_isa_pkg::opcode_e'(instr_word[6:2]);
  assign rs1    = instr_word[19:15];
  assign rs2    = instr_word[24:20];
  assign rd     = instr_word[11:7];
  assign funct3 = instr_word[14:12];
  assign funct7 = instr_word[31:25];

  assign imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
  assign imm_u = {instr_word[31:12], 12'b0};
  assign imm_j = {{12{instr_word[31]}}, instr_word[19:12], instr_word[20],
                  instr_word[30:21], 1'b0};
  assign imm_b = {{20{instr_word[31]}}, instr_word[7], instr_word[30:25],
                  instr_word[11:8], 1'b0};

  // Operand fetch, write port value wins
  assign rf.rs1_sel = rs1;
  assign rf.rs2_sel = rs2;
  assign rs1_data = (rf.wr_en && rf.wr_sel == rs1) ? rf.wr_data : rf.rs1_data;
  assign rs2_data = (rf.wr_en && rf.wr_sel == rs2) ? rf.wr_data : rf.rs2_data;

  // --------------------
  // Operation decoder
  always_comb begin
    instr_valid = 1'b0;
    writer      = 1'b0;
    rs1_en      = 1'b0;
    rs2_en      = 1'b0;
    aluop       = rv_isa_pkg::ALU_ADD;
    op1         = instr_pc;           // pc + 4 unless overridden
    op2         = 32'd4;
    base        = instr_pc;
    offset      = 32'd4;
    case (op)
      rv_isa_pkg::OPC_LUI: begin
        op1 = '0;
        op2 = imm_u;
        writer = 1'b1;
        instr_valid = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        op2 = imm_u;
        writer = 1'b1;
        instr_valid = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        offset = imm_j;
        writer = 1'b1;
        instr_valid = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        base = rs1_data;
        offset = imm_i;
        rs1_en = 1'b1;
        writer = 1'b1;
        instr_valid = funct3 == 3'b000;
      end
      rv_isa_pkg::OPC_BR: begin
        offset = imm_b;
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        instr_valid = funct3[2:1] != 2'b01;   // 010 and 011 unused
      end
      rv_isa_pkg::OPC_OPIMM: begin
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          aluop = rv_isa_pkg::aluop_e'({funct7[5], funct3});
        end else begin
          aluop = rv_isa_pkg::aluop_e'({1'b0, funct3});
        end
        op1 = rs1_data;
        op2 = imm_i;
        rs1_en = 1'b1;
        writer = 1'b1;
        case (funct3)
          3'b001:  instr_valid = funct7 == 7'd0;                        // SLLI
          3'b101:  instr_valid = funct7 == 7'd0 || funct7 == 7'd32;     // SRLI/SRAI
          default: instr_valid = 1'b1;
        endcase
      end
      rv_isa_pkg::OPC_OP: begin
        aluop = rv_isa_pkg::aluop_e'({funct7[5], funct3});
        op1 = rs1_data;
        op2 = rs2_data;
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        writer = 1'b1;
        // Only SUB and SRA use funct7 of 32
        instr_valid = funct7 == 7'd0
                   || (funct7 == 7'd32 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv_isa_pkg::OPC_MISC: begin
        // FENCE retires as a no-op
        instr_valid = funct3 == 3'b000 && funct7[6:3] == '0 && rs1 == '0 && rd == '0;
      end
      default: begin
      end
    endcase
  end

  assign illegal = (`RV_CATCH_ILLEGAL != 0)
                && (!instr_valid || instr_word[1:0] != 2'b11);

  // --------------------
  // Branches and jumps
  always_comb begin
    case (rv_isa_pkg::branch_e'(funct3))
      rv_isa_pkg::BEQ:  taken = rs1_data == rs2_data;
      rv_isa_pkg::BNE:  taken = rs1_data != rs2_data;
      rv_isa_pkg::BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
      rv_isa_pkg::BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      rv_isa_pkg::BLTU: taken = rs1_data < rs2_data;
      rv_isa_pkg::BGEU: taken = rs1_data >= rs2_data;
      default:          taken = 1'b0;
    endcase
  end

  assign target_sum = base + offset;
  assign target = (op == rv_isa_pkg::OPC_JALR) ? {target_sum[31:1], 1'b0} : target_sum;

  assign jump = !illegal && (op == rv_isa_pkg::OPC_JAL || op == rv_isa_pkg::OPC_JALR
                          || (op == rv_isa_pkg::OPC_BR && taken));
  assign misaligned = (`RV_CATCH_MISALIGNED_JMP != 0) && jump && target[1];
  assign regwr = writer && rd != '0 && !illegal && !misaligned;

  // --------------------
  // Hazard scoreboard
  assign pend_map = {pending, 1'b0};   // x0 never pending
  assign rs1_hz = rs1_en && pend_map[rs1] && !(rf.wr_en && rf.wr_sel == rs1);
  assign rs2_hz = rs2_en && pend_map[rs2] && !(rf.wr_en && rf.wr_sel == rs2);
  // One outstanding writer per register keeps the bit meaningful
  assign rd_hz  = regwr && pend_map[rd] && !(rf.wr_en && rf.wr_sel == rd);
  assign stall  = rs1_hz || rs2_hz || rd_hz;

  assign instr_rdy = (!out.vld || out.rdy) && !stall;
  assign issue     = instr_vld && instr_rdy;

  assign clr_mask = rf.wr_en ? (32'd1 << rf.wr_sel) : '0;
  assign set_mask = (issue && regwr) ? (32'd1 << rd) : '0;   // Set wins over clear

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr_mask[31:1]) | set_mask[31:1];
    end
  end

  // --------------------
  // Output register
  always_comb begin
    dec.pc         = instr_pc;
    dec.aluop      = aluop;
    dec.op1        = op1;
    dec.op2        = op2;
    dec.rd         = rd;
    dec.regwr      = regwr;
    dec.jump       = jump;
    dec.target     = target;
    dec.illegal    = illegal;
    dec.misaligned = misaligned;
  end

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      out.vld <= 1'b0;
    end else if (issue) begin
      out.vld <= 1'b1;
    end else if (out.rdy) begin
      out.vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) out.data <= dec;
  end

endmodule

`default_nettype wire

//--- design/rv_execute.sv
/* Execute stage, ALU computes the register result for the writeback stage */
`default_nettype none

module rv_execute (
  input logic     clk,
  input logic     rstz,
  stage_if.sink   in,
  stage_if.source out
);

  rv_pipe_pkg::exec_t res;
  logic [31:0] a, b, alu_res;
  logic [4:0]  shamt;

  assign a     = in.data.op1;
  assign b     = in.data.op2;
  assign shamt = b[4:0];

  // --------------------
  // ALU
  always_comb begin
    case (in.data.aluop)
      rv_isa_pkg::ALU_ADD:  alu_res = a + b;
      rv_isa_pkg::ALU_SUB:  alu_res = a - b;
      rv_isa_pkg::ALU_SLL:  alu_res = a << shamt;
      rv_isa_pkg::ALU_SLT:  alu_res = {31'b0, $signed(a) < $signed(b)};
      rv_isa_pkg::ALU_SLTU: alu_res = {31'b0, a < b};
      rv_isa_pkg::ALU_XOR:  alu_res = a ^ b;
      rv_isa_pkg::ALU_SRL:  alu_res = a >> shamt;
      rv_isa_pkg::ALU_SRA:  alu_res = $unsigned($signed(a) >>> shamt);
      rv_isa_pkg::ALU_OR:   alu_res = a | b;
      rv_isa_pkg::ALU_AND:  alu_res = a & b;
      default:              alu_res = a + b;   // Illegal encodings
    endcase
  end

  always_comb begin
    res.pc         = in.data.pc;
    res.rd         = in.data.rd;
    res.regwr      = in.data.regwr;
    res.data       = alu_res;
    res.jump       = in.data.jump;
    res.target     = in.data.target;
    res.illegal    = in.data.illegal;
    res.misaligned = in.data.misaligned;
  end

  // --------------------
  // Output register
  assign in.rdy = !out.vld || out.rdy;

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      out.vld <= 1'b0;
    end else if (in.vld && in.rdy) begin
      out.vld <= 1'b1;
    end else if (out.rdy) begin
      out.vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in.vld && in.rdy) out.data <= res;
  end

endmodule

`default_nettype wire

//--- design/rv_intf.sv
/* Pipeline stage handshake and register file access interfaces */
`default_nettype none

// Valid/ready stage boundary, payload type set per boundary
interface stage_if #(
  parameter type payload_t = logic
);
  logic     vld;
  logic     rdy;
  payload_t data;

  modport source (output vld, output data, input rdy);
  modport sink   (input vld, input data, output rdy);
endinterface

// Two read ports and one write port
interface regfile_if;
  logic [4:0]  rs1_sel;
  logic [4:0]  rs2_sel;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        wr_en;
  logic [4:0]  wr_sel;
  logic [31:0] wr_data;

  // Decode reads operands and watches the write port for forwarding
  modport read (
    output rs1_sel, output rs2_sel,
    input  rs1_data, input rs2_data,
    input  wr_en, input wr_sel, input wr_data
  );
  modport write (output wr_en, output wr_sel, output wr_data);
  modport storage (
    input  rs1_sel, input rs2_sel,
    output rs1_data, output rs2_data,
    input  wr_en, input wr_sel, input wr_data
  );
endinterface

`default_nettype wire

//--- design/rv_isa_pkg.sv
/* RV32I instruction set encodings
   Major opcodes, ALU operations and branch conditions */
`default_nettype none

package rv_isa_pkg;

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD  = 5'b00000,
    OPC_MISC  = 5'b00011,
    OPC_OPIMM = 5'b00100,
    OPC_AUIPC = 5'b00101,
    OPC_STORE = 5'b01000,
    OPC_OP    = 5'b01100,
    OPC_LUI   = 5'b01101,
    OPC_BR    = 5'b11000,
    OPC_JALR  = 5'b11001,
    OPC_JAL   = 5'b11011,
    OPC_SYS   = 5'b11100
  } opcode_e;

  // ALU operation is {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } aluop_e;

  // Branch conditions, funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_e;

endpackage

`default_nettype wire

//--- design/rv_pipe_pkg.sv
/* Pipeline payloads passed between the decode, execute and writeback stages */
`default_nettype none

package rv_pipe_pkg;

  // Decode to execute
  typedef struct packed {
    logic [31:0]         pc;
    rv_isa_pkg::aluop_e  aluop;
    logic [31:0]         op1;
    logic [31:0]         op2;
    logic [4:0]          rd;
    logic                regwr;
    logic                jump;    // Control transfer taken
    logic [31:0]         target;
    logic                illegal;
    logic                misaligned;
  } decode_t;

  // Execute to writeback
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        regwr;
    logic [31:0] data;    // ALU result
    logic        jump;
    logic [31:0] target;
    logic        illegal;
    logic        misaligned;
  } exec_t;

endpackage

`default_nettype wire

//--- design/rv_regfile.sv
/* General register file, x1 to x31, two async reads and one write */
`default_nettype none

module rv_regfile (
  input logic        clk,
  input logic        rstz,
  regfile_if.storage rf
);

  logic [31:0] regs [1:31];

  // x0 reads as zero
  assign rf.rs1_data = (rf.rs1_sel == '0) ? '0 : regs[rf.rs1_sel];
  assign rf.rs2_data = (rf.rs2_sel == '0) ? '0 : regs[rf.rs2_sel];

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wr_en && rf.wr_sel != '0) begin
      regs[rf.wr_sel] <= rf.wr_data;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_writeback.sv
/* Writeback stage, holds the retiring result and writes the register file */
`default_nettype none

module rv_writeback (
  input  logic        clk,
  input  logic        rstz,
  stage_if.sink       in,
  regfile_if.write    rf,
  output logic        result_vld,
  input  logic        result_rdy,
  output logic [31:0] result_pc,
  output logic [4:0]  result_rd,
  output logic [31:0] result_data,
  output logic        result_wr,
  output logic        result_jump,
  output logic [31:0] result_target,
  output logic        result_illegal,
  output logic        result_misaligned
);

  rv_pipe_pkg::exec_t res;

  assign in.rdy = !result_vld || result_rdy;

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      result_vld <= 1'b0;
    end else if (in.vld && in.rdy) begin
      result_vld <= 1'b1;
    end else if (result_rdy) begin
      result_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in.vld && in.rdy) res <= in.data;
  end

  // Register write commits on the result handshake
  assign rf.wr_en   = result_vld && result_rdy && res.regwr;
  assign rf.wr_sel  = res.rd;
  assign rf.wr_data = res.data;

  assign result_pc         = res.pc;
  assign result_rd         = res.rd;
  assign result_data       = res.data;
  assign result_wr         = res.regwr;
  assign result_jump       = res.jump;
  assign result_target     = res.target;
  assign result_illegal    = res.illegal;
  assign result_misaligned = res.misaligned;

endmodule

`default_nettype wire

//--- dv/core_trace.txt
# I <pc> <word>; T <name> opens a test group
# E <pc> <rd> <data> <wr> <jump> <target> <illegal> <misaligned>, in retirement order
T alu
I 00000000 00500093
E 00000000 01 00000005 1 0 00000000 0 0
I 00000004 ffd00113
E 00000004 02 fffffffd 1 0 00000000 0 0
I 00000008 002081b3
E 00000008 03 00000002 1 0 00000000 0 0
I 0000000c 40208233
E 0000000c 04 00000008 1 0 00000000 0 0
I 00000010 00309293
E 00000010 05 00000028 1 0 00000000 0 0
I 00000014 40115313
E 00000014 06 fffffffe 1 0 00000000 0 0
I 00000018 01c15393
E 00000018 07 0000000f 1 0 00000000 0 0
I 0000001c 00112433
E 0000001c 08 00000001 1 0 00000000 0 0
I 00000020 001134b3
E 00000020 09 00000000 1 0 00000000 0 0
I 00000024 0ff0c513
E 00000024 0a 000000fa 1 0 00000000 0 0
I 00000028 0020e5b3
E 00000028 0b fffffffd 1 0 00000000 0 0
I 0000002c 0f017613
E 0000002c 0c 000000f0 1 0 00000000 0 0
I 00000030 123456b7
E 00000030 0d 12345000 1 0 00000000 0 0
I 00000034 00001717
E 00000034 0e 00001034 1 0 00000000 0 0
I 00000038 00108013
E 00000038 00 00000000 0 0 00000000 0 0
T forwarding
I 0000003c 00100793
E 0000003c 0f 00000001 1 0 00000000 0 0
I 00000040 00f787b3
E 00000040 0f 00000002 1 0 00000000 0 0
I 00000044 00f787b3
E 00000044 0f 00000004 1 0 00000000 0 0
I 00000048 40178833
E 00000048 10 ffffffff 1 0 00000000 0 0
I 0000004c 00f848b3
E 0000004c 11 fffffffb 1 0 00000000 0 0
T branch
I 00000050 00108463
E 00000050 00 00000000 0 1 00000058 0 0
I 00000058 00109463
E 00000058 00 00000000 0 0 00000000 0 0
I 0000005c 00114663
E 0000005c 00 00000000 0 1 00000068 0 0
I 00000068 00116463
E 00000068 00 00000000 0 0 00000000 0 0
I 0000006c fe20dce3
E 0000006c 00 00000000 0 1 00000064 0 0
I 00000064 00117863
E 00000064 00 00000000 0 1 00000074 0 0
T jump
I 00000074 0080096f
E 00000074 12 00000078 1 1 0000007c 0 0
I 0000007c 009909e7
E 0000007c 13 00000080 1 1 00000080 0 0
I 00000080 00600a6f
E 00000080 00 00000000 0 1 00000086 0 1
I 00000084 10200ae7
E 00000084 00 00000000 0 1 00000102 0 1
I 00000088 00000363
E 00000088 00 00000000 0 1 0000008e 0 1
T illegal
I 0000008c 0000ab03
E 0000008c 00 00000000 0 0 00000000 1 0
I 00000090 00112023
E 00000090 00 00000000 0 0 00000000 1 0
I 00000094 30009bf3
E 00000094 00 00000000 0 0 00000000 1 0
I 00000098 00000073
E 00000098 00 00000000 0 0 00000000 1 0
I 0000009c 02208c33
E 0000009c 00 00000000 0 0 00000000 1 0
I 000000a0 0ff0000f
E 000000a0 00 00000000 0 0 00000000 0 0
I 000000a4 001c0c93
E 000000a4 19 00000001 1 0 00000000 0 0

//--- dv/tb_checker.sv
/* Result checker for the RV32I core testbench
   Compares each retired result with the next expected record of the trace */
`default_nettype none

module tb_checker (
  input  logic        clk,
  input  logic        rstz,
  input  logic        result_vld,
  input  logic        result_rdy,
  input  logic [31:0] result_pc,
  input  logic [4:0]  result_rd,
  input  logic [31:0] result_data,
  input  logic        result_wr,
  input  logic        result_jump,
  input  logic [31:0] result_target,
  input  logic        result_illegal,
  input  logic        result_misaligned,
  output logic        done,
  output int          check_cnt,
  output int          err_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [15:0] grp;          // Index into grp_names
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        wr;
    logic        jump;
    logic [31:0] target;
    logic        illegal;
    logic        misaligned;
  } expect_t;

  expect_t exp_q[$];
  string   grp_names[$];
  int      n_expected = 0;
  int      load_errs = 0;
  int      cmp_errs = 0;
  int      grp_cnt = 0;
  int      grp_first_err = 0;
  logic    loaded = 1'b0;

  assign done    = loaded && (check_cnt >= n_expected);
  assign err_cnt = load_errs + cmp_errs;

  // --------------------
  // Expected records
  initial begin : load_expected
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] pc, rd, data, wr, jump, target, ill, mis;
    expect_t     rec;
    fd = $fopen("dv/core_trace.txt", "r");
    if (fd == 0) begin
      $display("Checker cannot open dv/core_trace.txt");
      load_errs = 1;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.substr(0, 0) == "T") begin
          n = $sscanf(line, "T %s", name);
          grp_names.push_back(name);
        end else if (line.substr(0, 0) == "E") begin
          n = $sscanf(line, "E %h %h %h %h %h %h %h %h",
                      pc, rd, data, wr, jump, target, ill, mis);
          if (n != 8) begin
            $display("Malformed expected record in trace: %s", line);
            load_errs++;
          end else begin
            if (grp_names.size() == 0) grp_names.push_back("ungrouped");
            rec.grp        = 16'(grp_names.size() - 1);
            rec.pc         = pc;
            rec.rd         = rd[4:0];
            rec.data       = data;
            rec.wr         = wr[0];
            rec.jump       = jump[0];
            rec.target     = target;
            rec.illegal    = ill[0];
            rec.misaligned = mis[0];
            exp_q.push_back(rec);
          end
        end
      end
      $fclose(fd);
    end
    if (exp_q.size() == 0) $display("No expected records found in the trace");
    n_expected = exp_q.size();
    loaded     = 1'b1;
  end

  // --------------------
  // Comparison
  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %0d ns %s got %h expected %h", $time, name, got, want);
      cmp_errs++;
    end
  endtask

  task automatic compare_result(input expect_t e);
    check_field("result_pc", result_pc, e.pc);
    check_field("result_wr", 32'(result_wr), 32'(e.wr));
    check_field("result_jump", 32'(result_jump), 32'(e.jump));
    check_field("result_illegal", 32'(result_illegal), 32'(e.illegal));
    check_field("result_misaligned", 32'(result_misaligned), 32'(e.misaligned));
    if (e.wr) begin            // rd and data only mean something on a write
      check_field("result_rd", 32'(result_rd), 32'(e.rd));
      check_field("result_data", result_data, e.data);
    end
    if (e.jump) check_field("result_target", result_target, e.target);
  endtask

  // Summary line once the last record of a group is checked
  task automatic report_group(input int idx);
    if (idx == exp_q.size() - 1 || exp_q[idx + 1].grp != exp_q[idx].grp) begin
      $display("Test %s: %0d results, %0d errors", grp_names[exp_q[idx].grp],
               grp_cnt, cmp_errs - grp_first_err);
      grp_cnt       = 0;
      grp_first_err = cmp_errs;
    end
  endtask

  // Outputs are stable half a cycle before the handshake edge
  always @(negedge clk) begin
    if (rstz && result_vld && result_rdy) begin
      if (check_cnt >= n_expected) begin
        $display("Unexpected retirement at pc %h after all expected results", result_pc);
        cmp_errs++;
      end else begin
        compare_result(exp_q[check_cnt]);
        grp_cnt++;
        report_group(check_cnt);
        check_cnt++;
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
/* Testbench top for the RV32I core
   Trace-driven instruction stream with random valid and ready gaps */
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_HALF        = 4;     // 8 ns period
  localparam int          RST_CYCLES      = 10;
  localparam int          CYCLES_PER_LINE = 40;
  localparam logic [15:0] LFSR_SEED       = 16'd48155;

  logic        clk = 1'b0;
  logic        rstz;
  logic        instr_vld;
  logic        instr_rdy;
  logic [31:0] instr_pc;
  logic [31:0] instr_word;
  logic        result_vld;
  logic        result_rdy;
  logic [31:0] result_pc;
  logic [4:0]  result_rd;
  logic [31:0] result_data;
  logic        result_wr;
  logic        result_jump;
  logic [31:0] result_target;
  logic        result_illegal;
  logic        result_misaligned;
  logic        done;
  int          check_cnt;
  int          err_cnt;

  logic [31:0] prog_pc[$];
  logic [31:0] prog_word[$];
  int          trace_lines = 0;
  int          stim_errs = 0;
  logic        loaded = 1'b0;
  logic [15:0] lfsr_state = LFSR_SEED;

  always #(CLK_HALF) clk = ~clk;

  rv_core_top u_rv_core_top (.*);

  tb_checker u_tb_checker (.*);

  // --------------------
  // Random gating
  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic rand_bit();
    lfsr_state = lfsr_step(lfsr_state);   // One step per bit
    return lfsr_state[0];
  endfunction

  // Keeps the instruction lines of the trace and counts the E lines
  task automatic load_program();
    int          fd;
    int          n;
    string       line;
    logic [31:0] pc;
    logic [31:0] word;
    fd = $fopen("dv/core_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/core_trace.txt, no instructions to drive");
      stim_errs++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.substr(0, 0) == "I") begin
          n = $sscanf(line, "I %h %h", pc, word);
          if (n == 2) begin
            prog_pc.push_back(pc);
            prog_word.push_back(word);
          end else begin
            $display("Malformed instruction line in trace: %s", line);
            stim_errs++;
          end
          trace_lines++;
        end else if (line.substr(0, 0) == "E") begin
          trace_lines++;
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  // --------------------
  // Stimulus
  initial begin : stimulus
    int   idx;
    logic fire;
    rstz       = 1'b0;
    instr_vld  = 1'b0;
    instr_pc   = '0;
    instr_word = '0;
    result_rdy = 1'b0;
    idx        = 0;
    load_program();
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rstz = 1'b1;
    forever begin
      @(negedge clk);
      fire = instr_vld && instr_rdy;    // Handshake of the coming edge
      @(posedge clk);
      #1;
      if (fire) idx++;
      if (!instr_vld || fire) begin     // Held until taken
        if (idx < prog_pc.size() && rand_bit()) begin
          instr_vld  = 1'b1;
          instr_pc   = prog_pc[idx];
          instr_word = prog_word[idx];
        end else begin
          instr_vld = 1'b0;
        end
      end
      result_rdy = rand_bit();
    end
  end

  // --------------------
  // End of run
  initial begin : finish_run
    wait (done === 1'b1);
    repeat (10) @(posedge clk);         // Room for a stray retirement
    $display("Checked %0d results, %0d errors", check_cnt, err_cnt + stim_errs);
    if (err_cnt == 0 && stim_errs == 0 && check_cnt > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    repeat (RST_CYCLES + CYCLES_PER_LINE * (trace_lines + 1)) @(posedge clk);
    $display("Timeout, only %0d results retired before the cycle limit", check_cnt);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_intf.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_core_top.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_top -o tb_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0
